/* Bender.yml */
package:
  name: system_top

sources:
  - common/radio_pkg.sv
  - src/ctrl_regs.sv
  - spi/spi_master.sv
  - radio_ctrl/radio_ctrl.sv
  - src/system_top.sv
  - target: simulation
    files:
      - dv/system_top_asserts.sv
      - dv/system_top_tb.sv

/* common/radio_pkg.sv */
package radio_pkg;

  // ********************************************************************
  // Widths
  // ********************************************************************

  localparam int unsigned UP_ADDR_W = 4;
  localparam int unsigned UP_DATA_W = 32;
  localparam int unsigned GPIO_W    = 64;

  typedef logic [UP_ADDR_W-1:0] up_addr_t;
  typedef logic [UP_DATA_W-1:0] up_data_t;
  typedef logic [GPIO_W-1:0]    gpio_t;

  typedef logic [7:0] spi_byte_t;
  typedef logic [7:0] spi_csn_t;
  typedef logic [2:0] spi_cs_sel_t;

  // ********************************************************************
  // Register map
  // ********************************************************************

  localparam up_addr_t REG_GPIO_O_LO = up_addr_t'(0);
  localparam up_addr_t REG_GPIO_O_HI = up_addr_t'(1);
  localparam up_addr_t REG_GPIO_T_LO = up_addr_t'(2);
  localparam up_addr_t REG_GPIO_T_HI = up_addr_t'(3);
  // The input registers are read only
  localparam up_addr_t REG_GPIO_I_LO = up_addr_t'(4);
  localparam up_addr_t REG_GPIO_I_HI = up_addr_t'(5);
  localparam up_addr_t REG_SPI       = up_addr_t'(6);

  // GPIO bits that carry the transceiver requests
  localparam int unsigned GPIO_EN_BIT    = 47;
  localparam int unsigned GPIO_TXNRX_BIT = 48;

  // One SPI command, cs_sel sits above the byte as in the register layout
  typedef struct packed {
    spi_cs_sel_t cs_sel;
    spi_byte_t   tx_byte;
  } spi_cmd_s;

  // Radio control sequencing
  typedef enum logic [1:0] {
    RC_STEADY,
    RC_DRAIN,
    RC_SWITCH
  } radio_state_e;

endpackage

/* dv/system_top_asserts.sv */
module system_top_asserts import radio_pkg::*; (
  input logic     sys_clk_i,
  input logic     rst_n_i,
  input logic     enable_i,
  input logic     txnrx_i,
  input logic     busy_i,
  input spi_csn_t csn_i,
  input logic     sclk_i
);

  // Read by the testbench at the end of the run
  int unsigned fail_cnt = 0;

  // The transceiver mode may only move while it is disabled
  txnrx_stable: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
    !$stable(txnrx_i) |-> (!enable_i && !$past(enable_i)))
    else begin
      fail_cnt++;
      $error("txnrx changed while enable was high");
    end

  // One slave at a time
  csn_one_low: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
    busy_i |-> $onehot(~csn_i))
    else begin
      fail_cnt++;
      $error("chip select is not one-low during a transfer");
    end

  sclk_idle: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
    !busy_i |-> !sclk_i)
    else begin
      fail_cnt++;
      $error("spi_clk is high while the SPI master is idle");
    end

endmodule

bind radio_ctrl system_top_asserts radio_ctrl_asserts_i (
  .sys_clk_i (sys_clk_i),
  .rst_n_i   (rst_n_i),
  .enable_i  (enable_o),
  .txnrx_i   (txnrx_o),
  .busy_i    (1'b0),
  .csn_i     (8'hff),
  .sclk_i    (1'b0));

bind spi_master system_top_asserts spi_master_asserts_i (
  .sys_clk_i (sys_clk_i),
  .rst_n_i   (rst_n_i),
  .enable_i  (1'b0),
  .txnrx_i   (1'b0),
  .busy_i    (busy_o),
  .csn_i     (spi_csn_o),
  .sclk_i    (spi_clk_o));

/* dv/system_top_tb.sv */
module system_top_tb import radio_pkg::*;;

  localparam int unsigned CLK_DIV      = 2;
  localparam int unsigned GUARD_CYCLES = 4;
  // Counted from the write strobe cycle up to the done cycle
  localparam int unsigned SPI_CYCLES   = 16 * CLK_DIV + 2;
  localparam int unsigned RADIO_CYCLES = 2 * GUARD_CYCLES + 4;

  typedef enum logic [2:0] {
    OP_WR, OP_RD, OP_PIN, OP_SPI, OP_SPI_BUSY, OP_RADIO
  } op_e;

  typedef struct packed {
    op_e      op;
    up_addr_t addr;
    up_data_t data;
    up_data_t exp;
  } step_s;

  logic      sys_clk = 1'b0;
  logic      rst_n;
  logic      up_wr;
  logic      up_rd;
  up_addr_t  up_addr;
  up_data_t  up_wdata;
  up_data_t  up_rdata;
  logic      up_rdata_valid;
  gpio_t     gpio_i;
  gpio_t     gpio_o;
  gpio_t     gpio_tri;
  logic      spi_csn_0;
  logic      spi_clk;
  logic      spi_mosi;
  logic      spi_miso;
  logic      enable;
  logic      txnrx;

  step_s       steps[$];
  int unsigned err_cnt     = 0;
  int unsigned cycle_cnt   = 0;
  int unsigned cycle_limit = 0;
  int          seed        = 32'h72dc_b9f4;
  // Transceiver mode that the last radio step should have left behind
  logic        txnrx_exp   = 1'b0;

  // SPI slave model state
  spi_byte_t   slave_tx;
  spi_byte_t   slave_rx;
  int unsigned slave_bits  = 0;
  int unsigned miso_idx    = 0;
  int unsigned cs0_low_cnt = 0;

  system_top #(.CLK_DIV(CLK_DIV), .GUARD_CYCLES(GUARD_CYCLES)) system_top_i (
    .sys_clk_i        (sys_clk),
    .rst_n_i          (rst_n),
    .up_wr_i          (up_wr),
    .up_rd_i          (up_rd),
    .up_addr_i        (up_addr),
    .up_wdata_i       (up_wdata),
    .up_rdata_o       (up_rdata),
    .up_rdata_valid_o (up_rdata_valid),
    .gpio_i_i         (gpio_i),
    .gpio_o_o         (gpio_o),
    .gpio_t_o         (gpio_tri),
    .spi_csn_0_o      (spi_csn_0),
    .spi_clk_o        (spi_clk),
    .spi_mosi_o       (spi_mosi),
    .spi_miso_i       (spi_miso),
    .enable_o         (enable),
    .txnrx_o          (txnrx));

  always #2 sys_clk = ~sys_clk;

  always @(posedge sys_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("ERROR: the run did not finish within %0d cycles", cycle_limit);
      $display("tests failed");
      $finish;
    end
  end

  // ********************************************************************
  // SPI slave, mode 0, MSB first
  // ********************************************************************

  always @(negedge spi_csn_0) begin
    miso_idx = 7;
    spi_miso <= slave_tx[7];
  end

  always @(negedge spi_clk) begin
    if (miso_idx > 0) begin
      miso_idx = miso_idx - 1;
      spi_miso <= slave_tx[miso_idx];
    end
  end

  always @(posedge spi_clk) begin
    if (!spi_csn_0) begin
      slave_rx   = {slave_rx[6:0], spi_mosi};
      slave_bits = slave_bits + 1;
    end
  end

  always @(negedge sys_clk) begin
    if (!spi_csn_0) cs0_low_cnt = cs0_low_cnt + 1;
  end

  // ********************************************************************
  // Checks and bus access
  // ********************************************************************

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic bus_write(input up_addr_t addr, input up_data_t data);
    @(posedge sys_clk);
    up_wr    <= 1'b1;
    up_addr  <= addr;
    up_wdata <= data;
    @(posedge sys_clk);
    up_wr <= 1'b0;
  endtask

  task automatic bus_read(input up_addr_t addr, output up_data_t data);
    int unsigned waited;
    waited = 0;
    data   = '0;
    @(posedge sys_clk);
    up_rd   <= 1'b1;
    up_addr <= addr;
    @(posedge sys_clk);
    up_rd <= 1'b0;
    // The valid strobe lasts one cycle, so look between edges
    do begin
      @(negedge sys_clk);
      waited++;
    end while (!up_rdata_valid && waited < 8);
    if (up_rdata_valid) begin
      data = up_rdata;
    end else begin
      err_cnt++;
      $display("ERROR: read of address %0d got no read data strobe", addr);
    end
  endtask

  task automatic wait_spi_idle();
    up_data_t    status;
    int unsigned polls;
    polls = 0;
    do begin
      bus_read(REG_SPI, status);
      polls++;
    end while (status[16] && polls < SPI_CYCLES);
    if (status[16]) begin
      err_cnt++;
      $display("ERROR: SPI master still busy after %0d status reads", polls);
    end
  endtask

  task automatic spi_transfer(input up_data_t cmd, input spi_byte_t miso_byte);
    spi_cmd_s    sent;
    int unsigned cycles;
    up_data_t    status;
    sent        = spi_cmd_s'(cmd[10:0]);
    slave_tx    = miso_byte;
    slave_bits  = 0;
    cs0_low_cnt = 0;
    bus_write(REG_SPI, cmd);
    if (sent.cs_sel == 0) begin
      @(negedge sys_clk);
      check("spi_csn_0_o", spi_csn_0, 1'b0);
      cycles = 2;
      while (!spi_csn_0 && cycles < 2 * SPI_CYCLES) begin
        @(negedge sys_clk);
        cycles++;
      end
      check("spi_transfer_cycles", cycles, SPI_CYCLES);
      check("spi_mosi_o", slave_rx, sent.tx_byte);
      check("spi_mosi_bits", slave_bits, 8);
      bus_read(REG_SPI, status);
      check("up_rdata_o", status, up_data_t'(miso_byte));
    end else begin
      wait_spi_idle();
      check("spi_csn_0_o_low_cycles", cs0_low_cnt, 0);
      check("spi_mosi_bits", slave_bits, 0);
    end
  endtask

  task automatic spi_busy_drop(input up_data_t cmd, input up_data_t late_cmd);
    slave_bits = 0;
    bus_write(REG_SPI, cmd);
    bus_write(REG_SPI, late_cmd);
    wait_spi_idle();
    // Leave room for a second byte that should never start
    repeat (4) @(negedge sys_clk);
    check("spi_mosi_bits", slave_bits, 8);
    check("spi_mosi_o", slave_rx, cmd[7:0]);
  endtask

  task automatic radio_step(input up_data_t hi_word);
    logic        en_req;
    logic        txnrx_req;
    int unsigned cycles;
    en_req    = hi_word[GPIO_EN_BIT-32];
    txnrx_req = hi_word[GPIO_TXNRX_BIT-32];
    cycles    = 0;
    if (txnrx_req == txnrx_exp) begin
      bus_write(REG_GPIO_O_HI, hi_word);
      @(negedge sys_clk);
      check("gpio_o_o[63:32]", gpio_o[63:32], hi_word);
      @(negedge sys_clk);
      check("enable_o", enable, en_req);
      check("txnrx_o", txnrx, txnrx_req);
    end else begin
      bus_write(REG_GPIO_O_HI, hi_word);
      repeat (2) @(negedge sys_clk);
      check("enable_o", enable, 1'b0);
      while (txnrx != txnrx_req && cycles < RADIO_CYCLES) begin
        @(negedge sys_clk);
        cycles++;
      end
      if (cycles < GUARD_CYCLES) begin
        err_cnt++;
        $display("ERROR: txnrx_o changed %0d cycles after enable_o fell", cycles);
      end
      // Enable follows the request again once the switch interval is over
      repeat (GUARD_CYCLES + 1) @(negedge sys_clk);
      check("enable_o", enable, en_req);
      check("txnrx_o", txnrx, txnrx_req);
    end
    txnrx_exp = txnrx_req;
  endtask

  task automatic apply_step(input step_s s);
    up_data_t got;
    case (s.op)
      OP_WR: begin
        bus_write(s.addr, s.data);
        @(negedge sys_clk);
        case (s.addr)
          REG_GPIO_O_LO: check("gpio_o_o[31:0]", gpio_o[31:0], s.data);
          REG_GPIO_O_HI: check("gpio_o_o[63:32]", gpio_o[63:32], s.data);
          REG_GPIO_T_LO: check("gpio_t_o[31:0]", gpio_tri[31:0], s.data);
          REG_GPIO_T_HI: check("gpio_t_o[63:32]", gpio_tri[63:32], s.data);
          default: ;
        endcase
      end
      OP_RD: begin
        bus_read(s.addr, got);
        check("up_rdata_o", got, s.exp);
      end
      OP_PIN: begin
        @(posedge sys_clk);
        if (s.addr == REG_GPIO_I_HI) gpio_i[63:32] <= s.data;
        else gpio_i[31:0] <= s.data;
        repeat (2) @(posedge sys_clk);
      end
      OP_SPI:      spi_transfer(s.data, spi_byte_t'(s.exp));
      OP_SPI_BUSY: spi_busy_drop(s.data, s.exp);
      default:     radio_step(s.data);
    endcase
  endtask

  function automatic void add_step(op_e kind, up_addr_t a, up_data_t d, up_data_t e);
    steps.push_back(step_s'{op: kind, addr: a, data: d, exp: e});
  endfunction

  function automatic void build_table();
    up_data_t r[4];
    up_data_t p[2];
    spi_byte_t b;
    foreach (r[i]) r[i] = $random(seed);
    foreach (p[i]) p[i] = $random(seed);
    // Keep the radio requests idle until the radio steps
    r[1] = r[1] & ~32'h0001_8000;
    foreach (r[i]) add_step(OP_WR, up_addr_t'(i), r[i], r[i]);
    foreach (r[i]) add_step(OP_RD, up_addr_t'(i), '0, r[i]);
    add_step(OP_WR, REG_GPIO_I_LO, $random(seed), '0);
    add_step(OP_WR, up_addr_t'(9), $random(seed), '0);
    foreach (r[i]) add_step(OP_RD, up_addr_t'(i), '0, r[i]);
    add_step(OP_RD, REG_GPIO_I_LO, '0, '0);
    add_step(OP_RD, up_addr_t'(9), '0, '0);
    add_step(OP_RD, up_addr_t'(15), '0, '0);
    add_step(OP_PIN, REG_GPIO_I_LO, p[0], '0);
    add_step(OP_PIN, REG_GPIO_I_HI, p[1], '0);
    add_step(OP_RD, REG_GPIO_I_LO, '0, p[0]);
    add_step(OP_RD, REG_GPIO_I_HI, '0, p[1]);
    for (int i = 0; i < 5; i++) begin
      b = $random(seed);
      add_step(OP_SPI, REG_SPI, {21'd0, (i < 3) ? 3'd0 : 3'(i + 1), b}, $random(seed));
    end
    b = $random(seed);
    add_step(OP_SPI_BUSY, REG_SPI, {24'd0, b}, {24'd0, ~b});
    add_step(OP_RADIO, REG_GPIO_O_HI, 32'h0000_8000, '0);
    add_step(OP_RADIO, REG_GPIO_O_HI, 32'h0000_0000, '0);
    add_step(OP_RADIO, REG_GPIO_O_HI, 32'h0000_8000, '0);
    add_step(OP_RADIO, REG_GPIO_O_HI, 32'h0001_8000, '0);
    add_step(OP_RADIO, REG_GPIO_O_HI, 32'h0001_0000, '0);
    add_step(OP_RADIO, REG_GPIO_O_HI, 32'h0000_8000, '0);
    add_step(OP_RADIO, REG_GPIO_O_HI, 32'h0001_0000, '0);
  endfunction

  initial begin
    rst_n    = 1'b0;
    up_wr    = 1'b0;
    up_rd    = 1'b0;
    up_addr  = '0;
    up_wdata = '0;
    gpio_i   = '0;
    spi_miso = 1'b0;
    slave_tx = '0;
    slave_rx = '0;
    build_table();
    cycle_limit = 16;
    foreach (steps[i]) begin
      case (steps[i].op)
        OP_SPI, OP_SPI_BUSY: cycle_limit += 2 * SPI_CYCLES;
        OP_RADIO:            cycle_limit += 2 * RADIO_CYCLES;
        default:             cycle_limit += 2 * 4;
      endcase
    end
    repeat (3) @(posedge sys_clk);
    rst_n <= 1'b1;
    @(negedge sys_clk);
    check("gpio_t_o", gpio_tri, '1);
    check("gpio_o_o", gpio_o, '0);
    check("spi_csn_0_o", spi_csn_0, 1'b1);
    check("spi_clk_o", spi_clk, 1'b0);
    check("enable_o", enable, 1'b0);
    check("txnrx_o", txnrx, 1'b0);
    foreach (steps[i]) apply_step(steps[i]);
    err_cnt += system_top_i.i_radio_ctrl.radio_ctrl_asserts_i.fail_cnt;
    err_cnt += system_top_i.i_spi_master.spi_master_asserts_i.fail_cnt;
    $display("errors: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* radio_ctrl/radio_ctrl.sv */
module radio_ctrl import radio_pkg::*; #(
  parameter int unsigned GUARD_CYCLES = 4
) (
  input  logic sys_clk_i,
  input  logic rst_n_i,

  input  logic en_req_i,
  input  logic txnrx_req_i,

  output logic enable_o,
  output logic txnrx_o
);

  localparam int unsigned CNT_W = (GUARD_CYCLES > 1) ? $clog2(GUARD_CYCLES) : 1;
  localparam logic [CNT_W-1:0] GUARD_LAST = CNT_W'(GUARD_CYCLES - 1);

  radio_state_e     state;
  logic [CNT_W-1:0] guard_cnt;
  logic             guard_done;
  logic             enable_q;
  logic             txnrx_q;
  logic             settled;

  // The transceiver mode matches the request
  assign settled    = (txnrx_q == txnrx_req_i);
  assign guard_done = (guard_cnt == GUARD_LAST);

  // ********************************************************************
  // Enable and txnrx sequencing
  // ********************************************************************

  // The transceiver must never see txnrx move while it is enabled, so
  // a mode change always runs through the drain and switch intervals
  always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state     <= RC_STEADY;
      guard_cnt <= '0;
      enable_q  <= 1'b0;
      txnrx_q   <= 1'b0;
    end else begin
      case (state)
        RC_STEADY: begin
          if (settled) begin
            enable_q <= en_req_i;
          end else begin
            enable_q  <= 1'b0;
            guard_cnt <= '0;
            state     <= RC_DRAIN;
          end
        end

        // Enable is low here, wait before touching txnrx
        RC_DRAIN: begin
          if (guard_done) begin
            guard_cnt <= '0;
            txnrx_q   <= txnrx_req_i;
            state     <= RC_SWITCH;
          end else begin
            guard_cnt <= guard_cnt + 1'b1;
          end
        end

        // Give the new mode time to settle before enabling again
        RC_SWITCH: begin
          if (guard_done) begin
            guard_cnt <= '0;
            state     <= RC_STEADY;
          end else begin
            guard_cnt <= guard_cnt + 1'b1;
          end
        end

        default: begin
          state <= RC_STEADY;
        end
      endcase
    end
  end

  assign enable_o = enable_q;
  assign txnrx_o  = txnrx_q;

endmodule

/* spi/spi_master.sv */
module spi_master import radio_pkg::*; #(
  parameter int unsigned CLK_DIV = 2
) (
  input  logic      sys_clk_i,
  input  logic      rst_n_i,

  input  logic      start_i,
  input  spi_cmd_s  cmd_i,
  output logic      busy_o,
  output logic      done_o,
  output spi_byte_t rx_byte_o,

  output spi_csn_t  spi_csn_o,
  output logic      spi_clk_o,
  output logic      spi_mosi_o,
  input  logic      spi_miso_i
);

  // Each half period of spi_clk lasts CLK_DIV system clocks
  localparam int unsigned DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLK_DIV - 1);

  logic             busy_q;
  logic             done_q;
  logic             sclk_q;
  spi_csn_t         csn_q;
  logic [DIV_W-1:0] div_cnt;
  logic [3:0]       half_cnt;
  spi_byte_t        shift_q;
  logic             miso_q;
  logic             accept;
  logic             half_tick;
  logic             last_half;

  assign accept    = start_i && !busy_q;
  assign half_tick = busy_q && (div_cnt == DIV_LAST);
  // The sixteenth half period ends with the last falling edge
  assign last_half = (half_cnt == 4'd15);

  // ********************************************************************
  // Sequencing of clock phases and chip select
  // ********************************************************************

  always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q   <= 1'b0;
      done_q   <= 1'b0;
      sclk_q   <= 1'b0;
      csn_q    <= '1;
      div_cnt  <= '0;
      half_cnt <= '0;
    end else begin
      done_q <= 1'b0;
      if (accept) begin
        busy_q   <= 1'b1;
        csn_q    <= ~(spi_csn_t'(1) << cmd_i.cs_sel);
        div_cnt  <= '0;
        half_cnt <= '0;
      end else if (busy_q) begin
        if (half_tick) begin
          div_cnt  <= '0;
          half_cnt <= half_cnt + 4'd1;
          sclk_q   <= ~sclk_q;
          // Deselect on the final falling edge and flag the byte as done
          if (last_half) begin
            busy_q <= 1'b0;
            csn_q  <= '1;
            done_q <= 1'b1;
          end
        end else begin
          div_cnt <= div_cnt + 1'b1;
        end
      end
    end
  end

  // ********************************************************************
  // Data shift register
  // ********************************************************************

  // The byte leaves from the top while MISO bits enter at the bottom,
  // so after eight falling edges the register holds the received byte
  always_ff @(posedge sys_clk_i) begin
    if (accept) begin
      shift_q <= cmd_i.tx_byte;
    end else if (half_tick) begin
      if (!sclk_q) begin
        // Rising edge, sample the slave
        miso_q <= spi_miso_i;
      end else begin
        shift_q <= {shift_q[6:0], miso_q};
      end
    end
  end

  assign busy_o     = busy_q;
  assign done_o     = done_q;
  assign rx_byte_o  = shift_q;
  assign spi_csn_o  = csn_q;
  assign spi_clk_o  = sclk_q;
  assign spi_mosi_o = shift_q[7];

endmodule

/* src/ctrl_regs.sv */
module ctrl_regs import radio_pkg::*; (
  input  logic      sys_clk_i,
  input  logic      rst_n_i,

  input  logic      up_wr_i,
  input  logic      up_rd_i,
  input  up_addr_t  up_addr_i,
  input  up_data_t  up_wdata_i,
  output up_data_t  up_rdata_o,
  output logic      up_rdata_valid_o,

  input  gpio_t     gpio_i_i,
  output gpio_t     gpio_o_o,
  output gpio_t     gpio_t_o,

  output logic      spi_start_o,
  output spi_cmd_s  spi_cmd_o,
  input  logic      spi_busy_i,
  input  logic      spi_done_i,
  input  spi_byte_t spi_rx_byte_i
);

  gpio_t     gpio_o_q;
  gpio_t     gpio_t_q;
  gpio_t     gpio_i_meta;
  gpio_t     gpio_i_sync;
  spi_byte_t spi_rx_q;
  up_data_t  rd_mux;
  up_data_t  rdata_q;
  logic      rdata_valid_q;

  // ********************************************************************
  // GPIO output and tristate registers
  // ********************************************************************

  // Pads start as inputs with all outputs low
  always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_o_q <= '0;
      gpio_t_q <= '1;
    end else if (up_wr_i) begin
      case (up_addr_i)
        REG_GPIO_O_LO: gpio_o_q[31:0]  <= up_wdata_i;
        REG_GPIO_O_HI: gpio_o_q[63:32] <= up_wdata_i;
        REG_GPIO_T_LO: gpio_t_q[31:0]  <= up_wdata_i;
        REG_GPIO_T_HI: gpio_t_q[63:32] <= up_wdata_i;
        default: ;
      endcase
    end
  end

  assign gpio_o_o = gpio_o_q;
  assign gpio_t_o = gpio_t_q;

  // Two flop synchronizer, the pads are asynchronous to sys_clk
  always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_i_meta <= '0;
      gpio_i_sync <= '0;
    end else begin
      gpio_i_meta <= gpio_i_i;
      gpio_i_sync <= gpio_i_meta;
    end
  end

  // ********************************************************************
  // SPI command and status
  // ********************************************************************

  // A command written while the engine is busy is simply lost
  assign spi_start_o = up_wr_i && (up_addr_i == REG_SPI) && !spi_busy_i;
  assign spi_cmd_o   = '{cs_sel:  spi_cs_sel_t'(up_wdata_i[10:8]),
                         tx_byte: spi_byte_t'(up_wdata_i[7:0])};

  always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      spi_rx_q <= '0;
    end else if (spi_done_i) begin
      spi_rx_q <= spi_rx_byte_i;
    end
  end

  // ********************************************************************
  // Read path
  // ********************************************************************

  always_comb begin
    case (up_addr_i)
      REG_GPIO_O_LO: rd_mux = gpio_o_q[31:0];
      REG_GPIO_O_HI: rd_mux = gpio_o_q[63:32];
      REG_GPIO_T_LO: rd_mux = gpio_t_q[31:0];
      REG_GPIO_T_HI: rd_mux = gpio_t_q[63:32];
      REG_GPIO_I_LO: rd_mux = gpio_i_sync[31:0];
      REG_GPIO_I_HI: rd_mux = gpio_i_sync[63:32];
      REG_SPI:       rd_mux = {15'd0, spi_busy_i, 8'd0, spi_rx_q};
      default:       rd_mux = '0;
    endcase
  end

  // Read data comes back one cycle after the strobe
  always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rdata_q       <= '0;
      rdata_valid_q <= 1'b0;
    end else begin
      rdata_valid_q <= up_rd_i;
      if (up_rd_i) begin
        rdata_q <= rd_mux;
      end
    end
  end

  assign up_rdata_o       = rdata_q;
  assign up_rdata_valid_o = rdata_valid_q;

endmodule

/* src/system_top.sv */
module system_top import radio_pkg::*; #(
  parameter int unsigned CLK_DIV      = 2,
  parameter int unsigned GUARD_CYCLES = 4
) (
  input  logic     sys_clk_i,
  input  logic     rst_n_i,

  // Processor register port
  input  logic     up_wr_i,
  input  logic     up_rd_i,
  input  up_addr_t up_addr_i,
  input  up_data_t up_wdata_i,
  output up_data_t up_rdata_o,
  output logic     up_rdata_valid_o,

  // GPIO pads, resolved by the board shell
  input  gpio_t    gpio_i_i,
  output gpio_t    gpio_o_o,
  output gpio_t    gpio_t_o,

  output logic     spi_csn_0_o,
  output logic     spi_clk_o,
  output logic     spi_mosi_o,
  input  logic     spi_miso_i,

  output logic     enable_o,
  output logic     txnrx_o
);

  gpio_t     gpio_o;
  logic      spi_start;
  spi_cmd_s  spi_cmd;
  logic      spi_busy;
  logic      spi_done;
  spi_byte_t spi_rx_byte;
  spi_csn_t  spi_csn;

  assign gpio_o_o = gpio_o;

  // Only the first chip select is routed off chip
  assign spi_csn_0_o = spi_csn[0];

  ctrl_regs i_ctrl_regs (
    .sys_clk_i        (sys_clk_i),
    .rst_n_i          (rst_n_i),
    .up_wr_i          (up_wr_i),
    .up_rd_i          (up_rd_i),
    .up_addr_i        (up_addr_i),
    .up_wdata_i       (up_wdata_i),
    .up_rdata_o       (up_rdata_o),
    .up_rdata_valid_o (up_rdata_valid_o),
    .gpio_i_i         (gpio_i_i),
    .gpio_o_o         (gpio_o),
    .gpio_t_o         (gpio_t_o),
    .spi_start_o      (spi_start),
    .spi_cmd_o        (spi_cmd),
    .spi_busy_i       (spi_busy),
    .spi_done_i       (spi_done),
    .spi_rx_byte_i    (spi_rx_byte));

  spi_master #(.CLK_DIV(CLK_DIV)) i_spi_master (
    .sys_clk_i  (sys_clk_i),
    .rst_n_i    (rst_n_i),
    .start_i    (spi_start),
    .cmd_i      (spi_cmd),
    .busy_o     (spi_busy),
    .done_o     (spi_done),
    .rx_byte_o  (spi_rx_byte),
    .spi_csn_o  (spi_csn),
    .spi_clk_o  (spi_clk_o),
    .spi_mosi_o (spi_mosi_o),
    .spi_miso_i (spi_miso_i));

  // Software drives the transceiver through two GPIO request bits
  radio_ctrl #(.GUARD_CYCLES(GUARD_CYCLES)) i_radio_ctrl (
    .sys_clk_i   (sys_clk_i),
    .rst_n_i     (rst_n_i),
    .en_req_i    (gpio_o[GPIO_EN_BIT]),
    .txnrx_req_i (gpio_o[GPIO_TXNRX_BIT]),
    .enable_o    (enable_o),
    .txnrx_o     (txnrx_o));

endmodule

/* system_top.f */
common/radio_pkg.sv
src/ctrl_regs.sv
spi/spi_master.sv
radio_ctrl/radio_ctrl.sv
src/system_top.sv
dv/system_top_asserts.sv
dv/system_top_tb.sv
